//--- verilog/ls_rs_pkg.sv
package ls_rs_pkg;

  localparam int RS_SIZE = 8;                // Entries in the station.
  localparam int SLOT_W  = $clog2(RS_SIZE);
  localparam int TAG_W   = 6;
  localparam int ROB_W   = 6;
  localparam int IMM_W   = 12;
  localparam int F3_W    = 3;

  typedef logic [TAG_W-1:0]  phys_tag_t;     // Physical register number.
  typedef logic [ROB_W-1:0]  rob_tag_t;      // Reorder-buffer entry of the instruction.
  typedef logic [IMM_W-1:0]  imm_t;          // Offset, sign extended later by the LSU.
  typedef logic [F3_W-1:0]   funct3_t;       // Access width and signedness.
  typedef logic [SLOT_W-1:0] slot_t;

  // Dispatch side slave.
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_PUSH,
    RX_ACK
  } rx_state_t;

  // Issue side master.
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_REQ,
    TX_WAIT_LOW
  } tx_state_t;

endpackage

//--- verilog/ls_disp_if.sv
`timescale 1ns/1ps

interface ls_disp_if;

  logic                  push;      // Single-cycle write strobe.
  ls_rs_pkg::rob_tag_t   rob;
  ls_rs_pkg::phys_tag_t  rd;
  logic                  is_store;
  ls_rs_pkg::funct3_t    funct3;
  ls_rs_pkg::imm_t       imm;
  ls_rs_pkg::phys_tag_t  src1;
  logic                  src1_rdy;
  ls_rs_pkg::phys_tag_t  src2;
  logic                  src2_rdy;
  logic                  full;      // All entries occupied.

  modport rx (
    output push, rob, rd, is_store, funct3, imm, src1, src1_rdy, src2, src2_rdy,
    input  full
  );

  modport rs (
    input  push, rob, rd, is_store, funct3, imm, src1, src1_rdy, src2, src2_rdy,
    output full
  );

endinterface

//--- verilog/ls_issue_if.sv
`timescale 1ns/1ps

interface ls_issue_if;

  logic                  take;      // Single-cycle hand-off of the selected entry.
  ls_rs_pkg::rob_tag_t   rob;
  ls_rs_pkg::phys_tag_t  rd;
  logic                  is_store;
  ls_rs_pkg::funct3_t    funct3;
  ls_rs_pkg::imm_t       imm;
  ls_rs_pkg::phys_tag_t  src1;
  ls_rs_pkg::phys_tag_t  src2;
  logic                  busy;      // Transmitter still owns an instruction.

  modport rs (
    output take, rob, rd, is_store, funct3, imm, src1, src2,
    input  busy
  );

  modport tx (
    input  take, rob, rd, is_store, funct3, imm, src1, src2,
    output busy
  );

endinterface

//--- verilog/ls_dispatch_rx.sv
`timescale 1ns/1ps

module ls_dispatch_rx (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 flush,
  input  logic                 disp_req,
  output logic                 disp_ack,
  input  ls_rs_pkg::rob_tag_t  rob,
  input  ls_rs_pkg::phys_tag_t rd,
  input  logic                 is_store,
  input  ls_rs_pkg::funct3_t   funct3,
  input  ls_rs_pkg::imm_t      imm,
  input  ls_rs_pkg::phys_tag_t src1,
  input  logic                 src1_rdy,
  input  ls_rs_pkg::phys_tag_t src2,
  input  logic                 src2_rdy,
  ls_disp_if.rx                disp
);

  ls_rs_pkg::rx_state_t state;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ls_rs_pkg::RX_IDLE;
    end else if (flush) begin
      state <= ls_rs_pkg::RX_IDLE;
    end else begin
      case (state)
        ls_rs_pkg::RX_IDLE: if (disp_req) state <= ls_rs_pkg::RX_PUSH;
        ls_rs_pkg::RX_PUSH: if (disp.push) state <= ls_rs_pkg::RX_ACK;
        ls_rs_pkg::RX_ACK:  if (!disp_req) state <= ls_rs_pkg::RX_IDLE;
        default:            state <= ls_rs_pkg::RX_IDLE;
      endcase
    end
  end

  // The rename stage only keeps its fields valid while req is high.
  always_ff @(posedge clk) begin
    if (state == ls_rs_pkg::RX_IDLE && disp_req) begin
      disp.rob      <= rob;
      disp.rd       <= rd;
      disp.is_store <= is_store;
      disp.funct3   <= funct3;
      disp.imm      <= imm;
      disp.src1     <= src1;
      disp.src1_rdy <= src1_rdy;
      disp.src2     <= src2;
      disp.src2_rdy <= src2_rdy;
    end
  end

  assign disp.push = (state == ls_rs_pkg::RX_PUSH) && !disp.full && !flush;
  assign disp_ack  = (state == ls_rs_pkg::RX_ACK) && !flush;   // Held back until the entry is in.

  // The rename stage keeps req high until it has seen ack.
  a_req_held: assert property (
    @(posedge clk) disable iff (!rst_n)
      (state == ls_rs_pkg::RX_PUSH) && !flush |-> disp_req
  );

endmodule

//--- verilog/ls_station.sv
`timescale 1ns/1ps

module ls_station (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 flush,
  input  logic                 wb0_valid,
  input  ls_rs_pkg::phys_tag_t wb0_tag,
  input  logic                 wb1_valid,
  input  ls_rs_pkg::phys_tag_t wb1_tag,
  ls_disp_if.rs                disp,
  ls_issue_if.rs               iss
);

  logic [ls_rs_pkg::RS_SIZE-1:0] occupied;
  logic [ls_rs_pkg::RS_SIZE-1:0] rdy1;
  logic [ls_rs_pkg::RS_SIZE-1:0] rdy2;
  logic [ls_rs_pkg::RS_SIZE-1:0] fire_vec;

  ls_rs_pkg::rob_tag_t  rob_q      [ls_rs_pkg::RS_SIZE];
  ls_rs_pkg::phys_tag_t rd_q       [ls_rs_pkg::RS_SIZE];
  logic                 is_store_q [ls_rs_pkg::RS_SIZE];
  ls_rs_pkg::funct3_t   funct3_q   [ls_rs_pkg::RS_SIZE];
  ls_rs_pkg::imm_t      imm_q      [ls_rs_pkg::RS_SIZE];
  ls_rs_pkg::phys_tag_t src1_q     [ls_rs_pkg::RS_SIZE];
  ls_rs_pkg::phys_tag_t src2_q     [ls_rs_pkg::RS_SIZE];

  ls_rs_pkg::slot_t free_slot;
  ls_rs_pkg::slot_t sel_slot;
  logic             any_ready;

  // True when either result bus carries this tag in the current cycle.
  function automatic logic woken(input ls_rs_pkg::phys_tag_t tag);
    woken = (wb0_valid && wb0_tag == tag) || (wb1_valid && wb1_tag == tag);
  endfunction

  assign fire_vec  = occupied & rdy1 & rdy2;
  assign any_ready = |fire_vec;
  assign disp.full = &occupied;

  // Lowest free slot for the next push.
  always_comb begin
    free_slot = '0;
    for (int i = ls_rs_pkg::RS_SIZE - 1; i >= 0; i--) begin
      if (!occupied[i]) begin
        free_slot = ls_rs_pkg::slot_t'(i);
      end
    end
  end

  // Lowest fully ready slot wins selection.
  always_comb begin
    sel_slot = '0;
    for (int i = ls_rs_pkg::RS_SIZE - 1; i >= 0; i--) begin
      if (fire_vec[i]) begin
        sel_slot = ls_rs_pkg::slot_t'(i);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      occupied <= '0;
      rdy1     <= '0;
      rdy2     <= '0;
    end else if (flush) begin
      occupied <= '0;
      rdy1     <= '0;
      rdy2     <= '0;
    end else begin
      for (int i = 0; i < ls_rs_pkg::RS_SIZE; i++) begin
        if (occupied[i] && woken(src1_q[i])) begin
          rdy1[i] <= 1'b1;
        end
        if (occupied[i] && woken(src2_q[i])) begin
          rdy2[i] <= 1'b1;
        end
      end
      if (iss.take) begin
        occupied[sel_slot] <= 1'b0;
      end
      // A tag broadcast in the push cycle would otherwise be missed.
      if (disp.push) begin
        occupied[free_slot] <= 1'b1;
        rdy1[free_slot]     <= disp.src1_rdy || woken(disp.src1);
        rdy2[free_slot]     <= disp.src2_rdy || woken(disp.src2);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (disp.push) begin
      rob_q[free_slot]      <= disp.rob;
      rd_q[free_slot]       <= disp.rd;
      is_store_q[free_slot] <= disp.is_store;
      funct3_q[free_slot]   <= disp.funct3;
      imm_q[free_slot]      <= disp.imm;
      src1_q[free_slot]     <= disp.src1;
      src2_q[free_slot]     <= disp.src2;
    end
  end

  assign iss.take     = any_ready && !iss.busy && !flush;
  assign iss.rob      = rob_q[sel_slot];
  assign iss.rd       = rd_q[sel_slot];
  assign iss.is_store = is_store_q[sel_slot];
  assign iss.funct3   = funct3_q[sel_slot];
  assign iss.imm      = imm_q[sel_slot];
  assign iss.src1     = src1_q[sel_slot];
  assign iss.src2     = src2_q[sel_slot];

  // The transmitter owns the entry from the cycle after take.
  a_take_then_busy: assert property (
    @(posedge clk) disable iff (!rst_n) iss.take |=> iss.busy
  );

  // A push never lands on a live entry.
  a_push_free_slot: assert property (
    @(posedge clk) disable iff (!rst_n) disp.push |-> !occupied[free_slot]
  );

endmodule

//--- verilog/ls_issue_tx.sv
`timescale 1ns/1ps

module ls_issue_tx (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  flush,
  ls_issue_if.tx                iss,
  output logic                  iss_req,
  input  logic                  iss_ack,
  output ls_rs_pkg::rob_tag_t   iss_rob,
  output ls_rs_pkg::phys_tag_t  iss_rd,
  output logic                  iss_is_store,
  output ls_rs_pkg::funct3_t    iss_funct3,
  output ls_rs_pkg::imm_t       iss_imm,
  output ls_rs_pkg::phys_tag_t  iss_src1,
  output ls_rs_pkg::phys_tag_t  iss_src2
);

  ls_rs_pkg::tx_state_t state;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ls_rs_pkg::TX_IDLE;
    end else if (flush) begin
      state <= ls_rs_pkg::TX_IDLE;
    end else begin
      case (state)
        ls_rs_pkg::TX_IDLE:     if (iss.take) state <= ls_rs_pkg::TX_REQ;
        ls_rs_pkg::TX_REQ:      if (iss_ack) state <= ls_rs_pkg::TX_WAIT_LOW;
        ls_rs_pkg::TX_WAIT_LOW: if (!iss_ack) state <= ls_rs_pkg::TX_IDLE;
        default:                state <= ls_rs_pkg::TX_IDLE;
      endcase
    end
  end

  // Loaded only on take, so the fields hold through the whole exchange.
  always_ff @(posedge clk) begin
    if (iss.take) begin
      iss_rob      <= iss.rob;
      iss_rd       <= iss.rd;
      iss_is_store <= iss.is_store;
      iss_funct3   <= iss.funct3;
      iss_imm      <= iss.imm;
      iss_src1     <= iss.src1;
      iss_src2     <= iss.src2;
    end
  end

  assign iss_req  = (state == ls_rs_pkg::TX_REQ) && !flush;
  assign iss.busy = (state != ls_rs_pkg::TX_IDLE);   // Clears only after ack has dropped.

  a_fields_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
      iss_req ##1 iss_req |-> $stable({iss_rob, iss_rd, iss_is_store, iss_funct3,
                                       iss_imm, iss_src1, iss_src2})
  );

endmodule

//--- verilog/ls_rs_top.sv
`timescale 1ns/1ps

module ls_rs_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 flush,
  input  logic                 disp_req,
  output logic                 disp_ack,
  input  ls_rs_pkg::rob_tag_t  disp_rob,
  input  ls_rs_pkg::phys_tag_t disp_rd,
  input  logic                 disp_is_store,
  input  ls_rs_pkg::funct3_t   disp_funct3,
  input  ls_rs_pkg::imm_t      disp_imm,
  input  ls_rs_pkg::phys_tag_t disp_src1,
  input  logic                 disp_src1_rdy,
  input  ls_rs_pkg::phys_tag_t disp_src2,
  input  logic                 disp_src2_rdy,
  input  logic                 wb0_valid,
  input  ls_rs_pkg::phys_tag_t wb0_tag,
  input  logic                 wb1_valid,
  input  ls_rs_pkg::phys_tag_t wb1_tag,
  output logic                 iss_req,
  input  logic                 iss_ack,
  output ls_rs_pkg::rob_tag_t  iss_rob,
  output ls_rs_pkg::phys_tag_t iss_rd,
  output logic                 iss_is_store,
  output ls_rs_pkg::funct3_t   iss_funct3,
  output ls_rs_pkg::imm_t      iss_imm,
  output ls_rs_pkg::phys_tag_t iss_src1,
  output ls_rs_pkg::phys_tag_t iss_src2
);

  ls_disp_if  disp_bus ();
  ls_issue_if iss_bus ();

  ls_dispatch_rx u_rx (
    .clk, .rst_n, .flush, .disp_req, .disp_ack,
    .rob (disp_rob), .rd (disp_rd), .is_store (disp_is_store), .funct3 (disp_funct3),
    .imm (disp_imm), .src1 (disp_src1), .src1_rdy (disp_src1_rdy),
    .src2 (disp_src2), .src2_rdy (disp_src2_rdy), .disp (disp_bus.rx)
  );

  ls_station u_station (
    .clk, .rst_n, .flush, .wb0_valid, .wb0_tag, .wb1_valid, .wb1_tag,
    .disp (disp_bus.rs), .iss (iss_bus.rs)
  );

  ls_issue_tx u_tx (
    .clk, .rst_n, .flush, .iss (iss_bus.tx), .iss_req, .iss_ack, .iss_rob, .iss_rd,
    .iss_is_store, .iss_funct3, .iss_imm, .iss_src1, .iss_src2
  );

endmodule

//--- sim/tb_ls_rs.sv
`timescale 1ns/1ps

module tb_ls_rs;

  localparam string VEC_FILE = "sim/ls_rs_vectors.txt";

  logic        clk;
  logic        rst_n;
  logic        flush;
  logic        disp_req;
  logic        disp_ack;
  logic [5:0]  disp_rob;
  logic [5:0]  disp_rd;
  logic        disp_is_store;
  logic [2:0]  disp_funct3;
  logic [11:0] disp_imm;
  logic [5:0]  disp_src1;
  logic        disp_src1_rdy;
  logic [5:0]  disp_src2;
  logic        disp_src2_rdy;
  logic        wb0_valid;
  logic [5:0]  wb0_tag;
  logic        wb1_valid;
  logic [5:0]  wb1_tag;
  logic        iss_req;
  logic        iss_ack;
  logic [5:0]  iss_rob;
  logic [5:0]  iss_rd;
  logic        iss_is_store;
  logic [2:0]  iss_funct3;
  logic [11:0] iss_imm;
  logic [5:0]  iss_src1;
  logic [5:0]  iss_src2;

  logic [39:0] issued [$];  // Fields of each acknowledged issue in the order they came.
  bit          hold;        // Keeps the load/store unit from acknowledging.
  int          seed = 27487;
  int          n_lines;
  int          cur_test;
  int          test_errors;
  int          errors;
  int          tests_run;
  int          tests_failed;

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ls_rs_top dut (.*);

  task automatic report_mismatch(input string name, input logic [11:0] got,
                                 input logic [11:0] exp);
    $display("Error: %s = %h, expected %h", name, got, exp);
    test_errors++;
  endtask

  // Four-phase dispatch; bp picks a result bus that fires in the push cycle.
  task automatic dispatch(input logic [5:0] rob, input logic [5:0] rd, input logic st,
                          input logic [2:0] f3, input logic [11:0] imm,
                          input logic [5:0] s1, input logic r1, input logic [5:0] s2,
                          input logic r2, input int bp, input logic [5:0] bt,
                          input bit stall);
    int n;
    bit early_ack;
    early_ack = 1'b0;
    @(posedge clk);
    disp_rob      <= rob;
    disp_rd       <= rd;
    disp_is_store <= st;
    disp_funct3   <= f3;
    disp_imm      <= imm;
    disp_src1     <= s1;
    disp_src1_rdy <= r1;
    disp_src2     <= s2;
    disp_src2_rdy <= r2;
    disp_req      <= 1'b1;
    @(posedge clk);
    if (bp == 1) begin
      wb0_valid <= 1'b1;
      wb0_tag   <= bt;
    end else if (bp == 2) begin
      wb1_valid <= 1'b1;
      wb1_tag   <= bt;
    end
    @(posedge clk);
    wb0_valid <= 1'b0;
    wb1_valid <= 1'b0;
    if (stall) begin
      repeat (20) begin
        if (disp_ack) early_ack = 1'b1;
        @(posedge clk);
      end
      if (early_ack) begin
        $display("Test %0d: disp_ack rose while the station was full", cur_test);
        test_errors++;
      end
      hold <= 1'b0;  // Draining the transmitter frees a slot.
    end
    n = 0;
    while (!disp_ack && n < 300) begin
      @(posedge clk);
      n++;
    end
    if (!disp_ack) begin
      $display("Test %0d: dispatch of rob %h was never acknowledged", cur_test, rob);
      test_errors++;
    end
    disp_req <= 1'b0;
    n = 0;
    while (disp_ack && n < 300) begin
      @(posedge clk);
      n++;
    end
    if (disp_ack) begin
      $display("Test %0d: disp_ack stayed high after disp_req fell", cur_test);
      test_errors++;
    end
  endtask

  task automatic broadcast(input int port, input logic [5:0] tag);
    @(posedge clk);
    if (port == 0) begin
      wb0_valid <= 1'b1;
      wb0_tag   <= tag;
    end else begin
      wb1_valid <= 1'b1;
      wb1_tag   <= tag;
    end
    @(posedge clk);
    wb0_valid <= 1'b0;
    wb1_valid <= 1'b0;
  endtask

  task automatic expect_issue(input logic [39:0] exp);
    int n;
    logic [39:0] got;
    n = 0;
    while (issued.size() == 0 && n < 300) begin
      @(posedge clk);
      n++;
    end
    if (issued.size() == 0) begin
      $display("Test %0d: issue of rob %h never happened", cur_test, exp[39:34]);
      test_errors++;
    end else begin
      got = issued.pop_front();
      if (got[39:34] !== exp[39:34]) report_mismatch("iss_rob", 12'(got[39:34]), 12'(exp[39:34]));
      if (got[33:28] !== exp[33:28]) report_mismatch("iss_rd", 12'(got[33:28]), 12'(exp[33:28]));
      if (got[27] !== exp[27]) report_mismatch("iss_is_store", 12'(got[27]), 12'(exp[27]));
      if (got[26:24] !== exp[26:24]) report_mismatch("iss_funct3", 12'(got[26:24]), 12'(exp[26:24]));
      if (got[23:12] !== exp[23:12]) report_mismatch("iss_imm", got[23:12], exp[23:12]);
      if (got[11:6] !== exp[11:6]) report_mismatch("iss_src1", 12'(got[11:6]), 12'(exp[11:6]));
      if (got[5:0] !== exp[5:0]) report_mismatch("iss_src2", 12'(got[5:0]), 12'(exp[5:0]));
    end
  endtask

  task automatic expect_no_issue(input int cycles);
    repeat (cycles) @(posedge clk);
    @(negedge clk);
    if (issued.size() != 0) begin
      $display("Test %0d: %0d instruction(s) issued that should not have", cur_test,
               issued.size());
      test_errors++;
      issued.delete();
    end
  endtask

  task automatic end_test();
    if (cur_test != 0) begin
      expect_no_issue(20);
      tests_run++;
      if (test_errors == 0) begin
        $display("Test %0d: passed", cur_test);
      end else begin
        $display("Test %0d: failed with %0d error(s)", cur_test, test_errors);
        tests_failed++;
      end
    end
    errors += test_errors;
    test_errors = 0;
  endtask

  task automatic run_vectors(input int fd);
    logic [7:0]    op;
    int            num;
    int            bp;
    logic [5:0]    rob;
    logic [5:0]    rd;
    logic          st;
    logic [2:0]    f3;
    logic [11:0]   imm;
    logic [5:0]    s1;
    logic          r1;
    logic [5:0]    s2;
    logic          r2;
    logic [5:0]    bt;
    logic [1023:0] line_buf;
    while ($fscanf(fd, " %c", op) == 1) begin
      case (op)
        "#": void'($fgets(line_buf, fd));
        "T": begin
          void'($fscanf(fd, "%d", num));
          end_test();
          cur_test = num;
        end
        "D", "S": begin
          void'($fscanf(fd, "%h %h %h %h %h %h %h %h %h %d %h",
                        rob, rd, st, f3, imm, s1, r1, s2, r2, bp, bt));
          dispatch(rob, rd, st, f3, imm, s1, r1, s2, r2, bp, bt, op == "S");
        end
        "E": begin
          void'($fscanf(fd, "%h %h %h %h %h %h %h", rob, rd, st, f3, imm, s1, s2));
          expect_issue({rob, rd, st, f3, imm, s1, s2});
        end
        "B": begin
          void'($fscanf(fd, "%d %h", bp, bt));
          broadcast(bp, bt);
        end
        "H": begin
          void'($fscanf(fd, "%d", num));
          @(posedge clk);
          hold <= (num != 0);
        end
        "N": begin
          void'($fscanf(fd, "%d", num));
          expect_no_issue(num);
        end
        "F": begin
          @(posedge clk);
          flush <= 1'b1;
          @(posedge clk);
          flush <= 1'b0;
        end
        default: begin
          $display("Unknown vector operation '%c' in %s", op, VEC_FILE);
          test_errors++;
        end
      endcase
    end
    end_test();
  endtask

  // Load/store unit model that acknowledges after 0 to 3 cycles.
  initial begin : responder
    int delay;
    forever begin
      @(posedge clk);
      if (iss_req && !hold) begin
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) @(posedge clk);
        if (iss_req) begin
          issued.push_back({iss_rob, iss_rd, iss_is_store, iss_funct3, iss_imm,
                            iss_src1, iss_src2});
          iss_ack <= 1'b1;
          do @(posedge clk); while (iss_req);
          iss_ack <= 1'b0;
        end
      end
    end
  end

  initial begin : main
    int fd;
    logic [1023:0] line_buf;
    rst_n         = 1'b0;
    flush         = 1'b0;
    disp_req      = 1'b0;
    disp_rob      = '0;
    disp_rd       = '0;
    disp_is_store = 1'b0;
    disp_funct3   = '0;
    disp_imm      = '0;
    disp_src1     = '0;
    disp_src1_rdy = 1'b0;
    disp_src2     = '0;
    disp_src2_rdy = 1'b0;
    wb0_valid     = 1'b0;
    wb0_tag       = '0;
    wb1_valid     = 1'b0;
    wb1_tag       = '0;
    iss_ack       = 1'b0;
    hold          = 1'b0;
    fd = $fopen(VEC_FILE, "r");
    if (fd != 0) begin
      while ($fgets(line_buf, fd) != 0) begin
        n_lines++;
      end
      $fclose(fd);
    end
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    if (n_lines == 0) begin
      $display("The vector file %s is missing or empty", VEC_FILE);
      errors++;
    end else begin
      fd = $fopen(VEC_FILE, "r");
      run_vectors(fd);
      $fclose(fd);
    end
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Budget of 50 cycles per vector line.
  initial begin : watchdog
    wait (n_lines > 0);
    repeat (n_lines * 50) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", n_lines * 50);
    $display(">>> FAIL");
    $finish;
  end

endmodule

//--- sim.f
verilog/ls_rs_pkg.sv
verilog/ls_disp_if.sv
verilog/ls_issue_if.sv
verilog/ls_dispatch_rx.sv
verilog/ls_station.sv
verilog/ls_issue_tx.sv
verilog/ls_rs_top.sv
sim/tb_ls_rs.sv

//--- Makefile
# Verilator build and run for the load/store reservation station.

VERILATOR ?= verilator
TOP       ?= tb_ls_rs
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)

check: run
	@if grep -q '>>> FAIL' $(LOG); then echo "Simulation failed."; exit 1; fi
	@grep -q '>>> PASS' $(LOG) || (echo "Simulation ended without a result."; exit 1)
	@echo "Simulation passed."

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/ls_rs_vectors.txt
# T id | D/S rob rd st f3 imm src1 rdy1 src2 rdy2 bport(0 none,1 wb0,2 wb1) btag | S: station full
# E rob rd st f3 imm src1 src2 | B port tag | H 1 hold, 0 release | N idle cycles | F flush
T 1
D 01 0a 0 2 7f0 03 1 04 1 0 00
E 01 0a 0 2 7f0 03 04
T 2
D 02 0b 1 2 004 15 0 16 1 0 00
N 20
B 0 2a
N 20
B 1 15
E 02 0b 1 2 004 15 16
T 3
D 03 0c 0 4 ffc 21 1 22 0 1 22
E 03 0c 0 4 ffc 21 22
T 4
H 1
D 10 20 0 2 010 01 1 02 1 0 00
D 11 21 1 2 020 01 1 03 1 0 00
D 12 22 0 0 030 01 1 04 1 0 00
D 13 23 1 1 040 01 1 05 1 0 00
D 14 24 0 4 050 01 1 06 1 0 00
D 15 25 1 2 060 01 1 07 1 0 00
D 16 26 0 5 070 01 1 08 1 0 00
D 17 27 1 0 080 01 1 09 1 0 00
D 18 28 0 2 090 01 1 0a 1 0 00
S 19 29 1 2 0a0 01 1 0b 1 0 00
E 10 20 0 2 010 01 02
E 11 21 1 2 020 01 03
E 19 29 1 2 0a0 01 0b
E 12 22 0 0 030 01 04
E 13 23 1 1 040 01 05
E 14 24 0 4 050 01 06
E 15 25 1 2 060 01 07
E 16 26 0 5 070 01 08
E 17 27 1 0 080 01 09
E 18 28 0 2 090 01 0a
T 5
D 20 3a 0 2 100 30 0 01 1 0 00
D 21 3b 1 2 104 02 1 31 0 0 00
F
B 0 30
B 1 31
N 20
D 22 3c 0 1 108 03 1 04 1 0 00
E 22 3c 0 1 108 03 04
